//--- ecc_cfg_regs.sv
module ecc_cfg_regs
    import ecc_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  cfg_req_t         cfg_req,
    output logic [CNT_W-1:0] cfg_rdata,
    output logic             bypass,
    input  logic             sbit_evt,
    input  logic             dbit_evt
);

    logic [CNT_W-1:0] sbit_cnt;
    logic [CNT_W-1:0] dbit_cnt;
    logic             ctrl_wr;
    logic             sbit_clr;
    logic             dbit_clr;

    // saturating count with clear taking priority.
    function automatic logic [CNT_W-1:0] cnt_next(
        input logic [CNT_W-1:0] cnt,
        input logic             clr,
        input logic             evt
    );
        if (clr) begin
            return '0;
        end
        if (evt && (cnt != '1)) begin
            return cnt + CNT_W'(1);
        end
        return cnt;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ctrl_wr  = cfg_req.wr && (cfg_req.addr == CFG_CTRL);
    assign sbit_clr = cfg_req.wr && (cfg_req.addr == CFG_SBIT_CNT);
    assign dbit_clr = cfg_req.wr && (cfg_req.addr == CFG_DBIT_CNT);

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass   <= 1'b0;
            sbit_cnt <= '0;
            dbit_cnt <= '0;
        end else begin
            if (ctrl_wr) begin
                bypass <= cfg_req.wdata[0];
            end
            sbit_cnt <= cnt_next(sbit_cnt, sbit_clr, sbit_evt);
            dbit_cnt <= cnt_next(dbit_cnt, dbit_clr, dbit_evt);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (cfg_req.addr)
            CFG_CTRL:     cfg_rdata = {{(CNT_W-1){1'b0}}, bypass};
            CFG_SBIT_CNT: cfg_rdata = sbit_cnt;
            CFG_DBIT_CNT: cfg_rdata = dbit_cnt;
            default:      cfg_rdata = '0;   // unmapped address.
        endcase
    end

endmodule

//--- ecc_check_gen.sv
module ecc_check_gen
    import ecc_pkg::*;
(
    input  ecc_data_t  data,
    output ecc_check_t check
);

    // data bits that feed check bit k.
    function automatic ecc_data_t check_select(input int unsigned k);
        ecc_data_t  sel;
        ecc_check_t col;
        sel = '0;
        for (int unsigned i = 0; i < DATA_W; i++) begin
            col = ecc_column(i);
            sel[i] = col[k];
        end
        return sel;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // check bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    generate
        for (genvar k = 0; k < CHECK_W; k++) begin : g_check
            assign check[k] = ^(data & check_select(k));   // parity of selected bits.
        end
    endgenerate

endmodule

//--- ecc_codec_props.sv
module ecc_codec_props
    import ecc_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic        in_ready,
    input ecc_word_t   in_word,
    input logic        out_valid,
    input logic        out_ready,
    input ecc_result_t out_result,
    input logic        s1_valid,
    input logic        bypass,
    input logic        s2_free
);

    int unsigned fail_cnt;
    int unsigned n_in_hold  = 0;
    int unsigned n_out_hold = 0;
    int unsigned n_flags    = 0;
    int unsigned n_bypass   = 0;
    int unsigned n_rst      = 0;
    int unsigned n_idle     = 0;
    logic        seen_in;       // input transfer since reset.
    logic        cap_bypass;    // bypass taken with the stage 1 word.

    always_ff @(posedge clk) begin
        if (rst) begin
            seen_in <= 1'b0;
        end else if (in_valid && in_ready) begin
            seen_in <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            cap_bypass <= bypass;
        end
    end

    assign fail_cnt = n_in_hold + n_out_hold + n_flags + n_bypass + n_rst + n_idle;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream protocol
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=> in_valid && $stable(in_word))
        else begin
            n_in_hold++;
            $error("input word or valid changed while stalled");
        end

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else begin
            n_out_hold++;
            $error("output result or valid changed while stalled");
        end

    rst_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            n_rst++;
            $error("out_valid high right after a reset cycle");
        end

    first_idle: assert property (@(posedge clk) disable iff (rst)
        !seen_in |-> !out_valid)
        else begin
            n_idle++;
            $error("out_valid high before any input transfer");
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    one_flag: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(out_result.sbit_err && out_result.dbit_err))
        else begin
            n_flags++;
            $error("single and double error flags set together");
        end

    bypass_quiet: assert property (@(posedge clk) disable iff (rst)
        s1_valid && cap_bypass && s2_free |=> !out_result.sbit_err && !out_result.dbit_err)
        else begin
            n_bypass++;
            $error("error flag set on a word captured in bypass");
        end

endmodule

bind ecc_correct_pipe ecc_codec_props i_props (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_word    (in_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result),
    .s1_valid   (s1_valid),
    .bypass     (bypass),
    .s2_free    (s2_free)
);

//--- ecc_codec_top.f
ecc_pkg.sv
ecc_check_gen.sv
ecc_syndrome_decode.sv
ecc_cfg_regs.sv
ecc_correct_pipe.sv
ecc_codec_top.sv
ecc_codec_props.sv
tb_ecc_codec.sv

//--- ecc_codec_top.sv
module ecc_codec_top
    import ecc_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  ecc_word_t        in_word,
    output logic             out_valid,
    input  logic             out_ready,
    output ecc_result_t      out_result,
    input  cfg_req_t         cfg_req,
    output logic [CNT_W-1:0] cfg_rdata
);

    logic bypass;
    logic sbit_evt;     // single error left the codec.
    logic dbit_evt;

    ecc_correct_pipe i_pipe (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .bypass     (bypass),
        .sbit_evt   (sbit_evt),
        .dbit_evt   (dbit_evt)
    );

    ecc_cfg_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_req   (cfg_req),
        .cfg_rdata (cfg_rdata),
        .bypass    (bypass),
        .sbit_evt  (sbit_evt),
        .dbit_evt  (dbit_evt)
    );

endmodule

//--- ecc_correct_pipe.sv
module ecc_correct_pipe
    import ecc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    output logic        in_ready,
    input  ecc_word_t   in_word,
    output logic        out_valid,
    input  logic        out_ready,
    output ecc_result_t out_result,
    input  logic        bypass,
    output logic        sbit_evt,
    output logic        dbit_evt
);

    // stage 1 holds the received word and its syndrome.
    logic       s1_valid;
    ecc_data_t  s1_data;
    ecc_check_t s1_syn;
    logic       s1_bypass;

    logic       s1_load;
    logic       s2_load;
    logic       s2_free;    // stage 2 empty or draining.
    logic       out_fire;

    ecc_check_t in_check;
    ecc_data_t  fix_mask;
    ecc_class_e fix_class;
    ecc_data_t  fix_data;
    ecc_check_t fix_check;
    logic       fix_sbit;
    logic       fix_dbit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign out_fire = out_valid && out_ready;
    assign s2_free  = !out_valid || out_ready;
    assign in_ready = !s1_valid || s2_free;
    assign s1_load  = in_valid && in_ready;
    assign s2_load  = s1_valid && s2_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready) begin
                s1_valid <= in_valid;
            end
            if (s2_free) begin
                out_valid <= s1_valid;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1 syndrome
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ecc_check_gen i_syn_gen (
        .data  (in_word.data),
        .check (in_check)
    );

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_data   <= in_word.data;
            s1_syn    <= in_word.check ^ in_check;
            s1_bypass <= bypass;    // sampled with the word.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // correct and re-encode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ecc_syndrome_decode i_decode (
        .syndrome  (s1_syn),
        .mask      (fix_mask),
        .err_class (fix_class)
    );

    assign fix_data = s1_bypass ? s1_data : (s1_data ^ fix_mask);
    assign fix_sbit = !s1_bypass && (fix_class == ECC_SINGLE);
    assign fix_dbit = !s1_bypass && (fix_class == ECC_DOUBLE);

    ecc_check_gen i_out_gen (
        .data  (fix_data),
        .check (fix_check)
    );

    // stage 2 is the output register.
    always_ff @(posedge clk) begin
        if (s2_load) begin
            out_result.data     <= fix_data;
            out_result.check    <= fix_check;
            out_result.sbit_err <= fix_sbit;
            out_result.dbit_err <= fix_dbit;
        end
    end

    // one pulse per flagged output transfer.
    assign sbit_evt = out_fire && out_result.sbit_err;
    assign dbit_evt = out_fire && out_result.dbit_err;

endmodule

//--- ecc_pkg.sv
package ecc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int DATA_W  = 99;
    localparam int CHECK_W = 8;
    localparam int POS_W   = CHECK_W - 1;   // position field of a column.
    localparam int CNT_W   = 16;

    typedef logic [DATA_W-1:0]  ecc_data_t;
    typedef logic [CHECK_W-1:0] ecc_check_t;

    // stream payloads
    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t check;
    } ecc_word_t;

    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t check;     // regenerated from corrected data.
        logic       sbit_err;
        logic       dbit_err;
    } ecc_result_t;

    typedef enum logic [1:0] {
        ECC_CLEAN,
        ECC_SINGLE,
        ECC_DOUBLE
    } ecc_class_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        CFG_CTRL     = 2'd0,
        CFG_SBIT_CNT = 2'd1,
        CFG_DBIT_CNT = 2'd2
    } cfg_addr_e;

    typedef struct packed {
        logic             wr;
        cfg_addr_e        addr;
        logic [CNT_W-1:0] wdata;
    } cfg_req_t;

    // Column of data bit idx. The data bits fill the code positions that are
    // not powers of two, starting at 3; the top bit makes the weight odd.
    function automatic ecc_check_t ecc_column(input int unsigned idx);
        int unsigned pos;
        ecc_check_t  col;
        pos = idx + 3;
        for (int k = 2; k < POS_W; k++) begin
            if (pos >= (32'd1 << k)) begin
                pos++;    // skip check position 2**k.
            end
        end
        col[POS_W-1:0] = pos[POS_W-1:0];
        col[CHECK_W-1] = ~^pos[POS_W-1:0];
        return col;
    endfunction

endpackage

//--- ecc_syndrome_decode.sv
module ecc_syndrome_decode
    import ecc_pkg::*;
(
    input  ecc_check_t syndrome,
    output ecc_data_t  mask,
    output ecc_class_e err_class
);

    logic check_hit;    // at most one syndrome bit set.
    logic data_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // correction mask
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    generate
        for (genvar i = 0; i < DATA_W; i++) begin : g_mask
            assign mask[i] = (syndrome == ecc_column(i));
        end
    endgenerate

    assign data_hit  = |mask;
    assign check_hit = (syndrome & (syndrome - CHECK_W'(1))) == '0;

    // Columns all have odd weight, so an even-weight nonzero syndrome can
    // only come from two flipped bits.
    always_comb begin
        if (syndrome == '0) begin
            err_class = ECC_CLEAN;
        end else if (data_hit || check_hit) begin
            err_class = ECC_SINGLE;
        end else begin
            err_class = ECC_DOUBLE;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build tb_ecc_codec with Verilator, run it, and look for the pass line in the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ecc_codec \
    -f ecc_codec_top.f -o tb_ecc_codec_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_ecc_codec_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "simulator returned a failing status"
cat sim.log
grep -qx "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- tb_ecc_codec.sv
module tb_ecc_codec
    import ecc_pkg::*;
();

    localparam int N_CLEAN     = 40;
    localparam int N_DATA      = 40;
    localparam int N_CHECK     = 16;
    localparam int N_DOUBLE    = 40;
    localparam int N_BYP       = 15;    // pairs of words.
    localparam int N_RESUME    = 20;
    localparam int N_STALL     = 80;
    localparam int N_WORDS     = N_CLEAN + N_DATA + N_CHECK + N_DOUBLE + 2 * N_BYP
                               + N_RESUME + N_STALL;
    localparam int TIMEOUT_CYC = N_WORDS * 20 + 200;

    typedef enum int {INJ_NONE, INJ_DATA, INJ_CHECK, INJ_DOUBLE} inject_e;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    ecc_word_t        in_word;
    logic             out_valid;
    logic             out_ready;
    ecc_result_t      out_result;
    cfg_req_t         cfg_req;
    logic [CNT_W-1:0] cfg_rdata;

    logic [31:0]      lfsr_state = 32'd97970;
    logic             stall_en = 1'b0;
    int               errors = 0;
    logic [CNT_W-1:0] exp_sbit_cnt = '0;
    logic [CNT_W-1:0] exp_dbit_cnt = '0;
    ecc_result_t      exp_q[$];
    string            name_q[$];
    ecc_result_t      mon_exp;
    string            mon_name;

    ecc_codec_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_word    (in_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result),
        .cfg_req    (cfg_req),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};    // x^32 + x^22 + x^2 + x + 1.
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // xor of the columns of all set data bits.
    function automatic ecc_check_t encode(input ecc_data_t d);
        ecc_check_t c;
        c = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) begin
                c = c ^ ecc_column(i);
            end
        end
        return c;
    endfunction

    // code bits 0..98 are data and the rest are check bits.
    function automatic ecc_word_t flip_code_bit(input ecc_word_t w, input int p);
        ecc_word_t r;
        r = w;
        if (p < DATA_W) begin
            r.data[p] = ~r.data[p];
        end else begin
            r.check[p - DATA_W] = ~r.check[p - DATA_W];
        end
        return r;
    endfunction

    task automatic step_ready();
        @(negedge clk);
        out_ready = stall_en ? (rand_bits(2) != 0) : 1'b1;
    endtask

    task automatic send_word(input ecc_word_t w, input ecc_result_t exp, input string name);
        logic done;
        done = 1'b0;
        in_valid = 1'b1;
        in_word  = w;
        while (!done) begin
            @(posedge clk);
            done = in_ready;
            step_ready();
        end
        exp_q.push_back(exp);
        name_q.push_back(name);
        in_valid = 1'b0;
    endtask

    task automatic send_case(input inject_e kind, input logic byp, input string name);
        ecc_data_t   d;
        ecc_word_t   w;
        ecc_result_t exp;
        int          p1;
        int          p2;
        for (int i = 0; i < DATA_W; i++) begin
            d[i] = lfsr_step();
        end
        w.data  = d;
        w.check = encode(d);
        exp     = '0;
        exp.data = d;
        case (kind)
            INJ_DATA: begin
                p1 = rand_bits(7) % DATA_W;
                w = flip_code_bit(w, p1);
                exp.sbit_err = 1'b1;
            end
            INJ_CHECK: begin
                p1 = rand_bits(3);
                w = flip_code_bit(w, DATA_W + p1);
                exp.sbit_err = 1'b1;
            end
            INJ_DOUBLE: begin
                p1 = rand_bits(7) % (DATA_W + CHECK_W);
                p2 = p1;
                while (p2 == p1) begin
                    p2 = rand_bits(7) % (DATA_W + CHECK_W);
                end
                w = flip_code_bit(flip_code_bit(w, p1), p2);
                exp.data = w.data;    // left uncorrected.
                exp.dbit_err = 1'b1;
            end
            default: ;
        endcase
        if (byp) begin
            exp.data     = w.data;
            exp.sbit_err = 1'b0;
            exp.dbit_err = 1'b0;
        end
        exp.check = encode(exp.data);
        send_word(w, exp, name);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step_ready();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input cfg_addr_e addr, input logic [CNT_W-1:0] wdata);
        cfg_req.wr    = 1'b1;
        cfg_req.addr  = addr;
        cfg_req.wdata = wdata;
        @(negedge clk);
        cfg_req.wr    = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_e addr, input logic [CNT_W-1:0] exp,
                            input string name);
        cfg_req.wr    = 1'b0;
        cfg_req.addr  = addr;
        cfg_req.wdata = '0;
        @(posedge clk);
        assert (cfg_rdata == exp) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, cfg_rdata);
        end
        @(negedge clk);
    endtask

    task automatic check_counters(input string phase);
        read_reg(CFG_SBIT_CNT, exp_sbit_cnt, {phase, "_sbit_cnt"});
        read_reg(CFG_DBIT_CNT, exp_dbit_cnt, {phase, "_dbit_cnt"});
    endtask

    task automatic clear_counter(input cfg_addr_e addr, input string name);
        write_reg(addr, '0);
        if (addr == CFG_SBIT_CNT) begin
            exp_sbit_cnt = '0;
        end else begin
            exp_dbit_cnt = '0;
        end
        read_reg(addr, '0, name);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("output transfer with no word outstanding");
            end
            if (exp_q.size() != 0) begin
                mon_exp  = exp_q.pop_front();
                mon_name = name_q.pop_front();
                assert (out_result == mon_exp) else begin
                    errors++;
                    $display("** Error %s: expected %h, actual %h",
                             mon_name, mon_exp, out_result);
                end
                if (mon_exp.sbit_err) exp_sbit_cnt++;
                if (mon_exp.dbit_err) exp_dbit_cnt++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout: the words did not all come out within %0d cycles", TIMEOUT_CYC);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        inject_e kind;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b1;
        cfg_req   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (N_CLEAN) send_case(INJ_NONE, 1'b0, "clean");
        drain();
        check_counters("clean");

        repeat (N_DATA) send_case(INJ_DATA, 1'b0, "single_data");
        repeat (N_CHECK) send_case(INJ_CHECK, 1'b0, "single_check");
        drain();
        check_counters("single");
        clear_counter(CFG_SBIT_CNT, "sbit_clear");

        repeat (N_DOUBLE) send_case(INJ_DOUBLE, 1'b0, "double");
        drain();
        check_counters("double");
        clear_counter(CFG_DBIT_CNT, "dbit_clear");

        // words in flight keep the bypass value they were captured with.
        write_reg(CFG_CTRL, 16'h0001);
        read_reg(CFG_CTRL, 16'h0001, "bypass_on");
        repeat (N_BYP) begin
            send_case(INJ_DATA, 1'b1, "bypass_single");
            send_case(INJ_DOUBLE, 1'b1, "bypass_double");
        end
        out_ready = 1'b0;    // last bypass words stay in both stages.
        write_reg(CFG_CTRL, 16'h0000);
        repeat (N_RESUME) send_case(INJ_DATA, 1'b0, "resume");
        drain();
        read_reg(CFG_CTRL, 16'h0000, "bypass_off");
        check_counters("bypass");

        stall_en = 1'b1;
        repeat (N_STALL) begin
            kind = inject_e'(rand_bits(2));
            send_case(kind, 1'b0, "stall");
        end
        drain();
        stall_en = 1'b0;
        step_ready();
        check_counters("stall");
        clear_counter(CFG_SBIT_CNT, "final_sbit_clear");
        clear_counter(CFG_DBIT_CNT, "final_dbit_clear");

        repeat (4) @(negedge clk);
        $display("errors: %0d  assertion failures: %0d",
                 errors, i_dut.i_pipe.i_props.fail_cnt);
        if (errors == 0 && i_dut.i_pipe.i_props.fail_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
